/* sources.f */
+incdir+design
+incdir+tb
design/rvIsaPkg.sv
design/coreCtrlPkg.sv
design/fetchDecode.sv
design/regFile.sv
design/execUnit.sv
design/dataMem.sv
design/controller.sv
design/rvCore.sv
tb/rvCore_checker.sv
tb/rvCore_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f sources.f --top-module rvCore_tb -o rvCoreSim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rvCoreSim > sim.log 2>&1
grep -q "ALL TESTS PASSED" sim.log && echo "simulation ok" || { cat sim.log; exit 1; }

/* tb/rvCore_model.svh */
`ifndef RVCORE_MODEL_SVH
`define RVCORE_MODEL_SVH

// integer result of the supported alu operations
function automatic logic [31:0] aluCalc(logic [2:0] f3, logic isSub, logic [31:0] a,
	logic [31:0] b);
	case (f3)
		3'b000: return isSub ? a - b : a + b;
		3'b010: return {31'b0, $signed(a) < $signed(b)};
		3'b100: return a ^ b;
		3'b110: return a | b;
		3'b111: return a & b;
		default: return 32'h0;
	endcase
endfunction

// executes the instruction at modelPc and returns its expected retire record
function automatic coreCtrlPkg::retireT modelStep();
	logic [31:0] instr;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immJ;
	logic [31:0] addr;
	logic [31:0] shifted;
	logic [31:0] val;
	logic [31:0] nextPc;
	logic [2:0] f3;
	logic [4:0] rd;
	coreCtrlPkg::retireT exp;
	instr = progWords[modelPc[`IMEM_AW+1:2]];
	f3 = instr[14:12];
	rd = instr[11:7];
	a = modelRegs[instr[19:15]];
	b = modelRegs[instr[24:20]];
	immI = {{20{instr[31]}}, instr[31:20]};
	immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	exp = '0;
	exp.pc = modelPc;
	nextPc = modelPc + 32'd4;
	val = 32'h0;
	case (instr[6:0])
		rvIsaPkg::OP: val = aluCalc(f3, instr[30], a, b);
		rvIsaPkg::OPIMM: val = aluCalc(f3, 1'b0, a, immI);
		rvIsaPkg::LOAD:
		begin
			addr = a + immI;
			exp.memAddr = addr;
			shifted = modelMem[addr[`DMEM_AW+1:2]] >> {addr[1:0], 3'b000};
			case (f3)
				3'b000: val = {{24{shifted[7]}}, shifted[7:0]};
				3'b001: val = {{16{shifted[15]}}, shifted[15:0]};
				3'b100: val = {24'b0, shifted[7:0]};
				3'b101: val = {16'b0, shifted[15:0]};
				default: val = shifted;
			endcase
		end
		rvIsaPkg::STORE:
		begin
			addr = a + immS;
			exp.memWriteEnable = 1'b1;
			exp.memAddr = addr;
			case (f3)
				3'b000: exp.memByteEnable = 4'b0001 << addr[1:0];
				3'b001: exp.memByteEnable = 4'b0011 << addr[1:0];
				default: exp.memByteEnable = 4'b1111;
			endcase
			exp.memWriteData = b << {addr[1:0], 3'b000};
			for (int i = 0; i < 4; i++)
				if (exp.memByteEnable[i])
					modelMem[addr[`DMEM_AW+1:2]][8*i +: 8] = exp.memWriteData[8*i +: 8];
		end
		rvIsaPkg::BRANCH:
		begin
			case (f3)
				3'b000: if (a == b) nextPc = modelPc + immB;
				3'b001: if (a != b) nextPc = modelPc + immB;
				3'b100: if ($signed(a) < $signed(b)) nextPc = modelPc + immB;
				3'b101: if ($signed(a) >= $signed(b)) nextPc = modelPc + immB;
				default: nextPc = modelPc + 32'd4;
			endcase
		end
		rvIsaPkg::JAL:
		begin
			val = modelPc + 32'd4;
			nextPc = modelPc + immJ;
		end
		rvIsaPkg::JALR:
		begin
			val = modelPc + 32'd4;
			nextPc = (a + immI) & 32'hFFFF_FFFE; // bit 0 cleared
		end
		default: nextPc = modelPc + 32'd4;
	endcase
	if (instr[6:0] != rvIsaPkg::STORE && instr[6:0] != rvIsaPkg::BRANCH)
	begin
		exp.regWriteEnable = 1'b1;
		exp.rd = rd;
		exp.regWriteData = val;
		if (rd != 5'd0)
			modelRegs[rd] = val; // x0 stays zero
	end
	modelPc = nextPc;
	return exp;
endfunction

`endif

/* tb/rvCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module rvCore_tb;

	localparam int PROG_LEN = 48; // random instructions before the halt
	localparam int HALT_PC = PROG_LEN * 4;
	localparam int TIMEOUT_NS = (PROG_LEN + 1 + 8) * 4 * 4 * 2;
	localparam int K_OP = 0;
	localparam int K_IMM = 1;
	localparam int K_LOAD = 2;
	localparam int K_STORE = 3;
	localparam int K_BRANCH = 4;
	localparam int K_JAL = 5;
	localparam int K_BASE = 6; // addi x31 ahead of a jalr
	localparam int K_JALR = 7;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic imemLoad;
	logic [`IMEM_AW-1:0] imemLoadAddr;
	logic [`DATA_WIDTH-1:0] imemLoadData;
	logic retireValid;
	coreCtrlPkg::retireT retire;

	logic [31:0] lcgState;
	logic [31:0] progWords [`IMEM_WORDS];
	int kinds [PROG_LEN+1];
	logic [31:0] modelRegs [32];
	logic [31:0] modelMem [`DMEM_WORDS];
	logic [31:0] modelPc;

	`include "rvCore_model.svh"

	rvCore UUT (
		.clk(clk),
		.reset(reset),
		.imemLoad(imemLoad),
		.imemLoadAddr(imemLoadAddr),
		.imemLoadData(imemLoadData),
		.retireValid(retireValid),
		.retire(retire)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch %s: got %h expected %h", name, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	// forward slot index, never onto a jalr whose base addi would be skipped
	function automatic int forwardTarget(int s, logic [1:0] k);
		int t;
		t = s + 1 + int'(k);
		if (t > PROG_LEN)
			t = PROG_LEN;
		if (kinds[t] == K_JALR)
			t++;
		return t;
	endfunction

	function automatic logic [2:0] aluF3(logic [7:0] r);
		case (r % 8'd5)
			8'd0: return 3'b000;
			8'd1: return 3'b010;
			8'd2: return 3'b100;
			8'd3: return 3'b110;
			default: return 3'b111;
		endcase
	endfunction

	function automatic logic [31:0] encodeSlot(int s);
		logic [31:0] r;
		logic [2:0] f3;
		logic [11:0] off;
		logic [12:0] immB;
		logic [20:0] immJ;
		r = nextRand();
		off = {6'b0, r[31:26]}; // aligned below 64
		case (kinds[s])
			K_OP:
			begin
				f3 = aluF3(r[31:24]);
				return {1'b0, (f3 == 3'b000) & r[23], 5'b0, 2'b00, r[2:0], 2'b00, r[5:3], f3,
					2'b00, r[8:6], rvIsaPkg::OP};
			end
			K_IMM: return {r[31:20], 2'b00, r[5:3], aluF3(r[19:12]), 2'b00, r[8:6],
				rvIsaPkg::OPIMM};
			K_LOAD:
			begin
				case (r[14:12] % 3'd5)
					3'd0: f3 = 3'b000;
					3'd1: f3 = 3'b001;
					3'd2: f3 = 3'b010;
					3'd3: f3 = 3'b100;
					default: f3 = 3'b101;
				endcase
				if (f3[1:0] == 2'b01)
					off[0] = 1'b0;
				if (f3 == 3'b010)
					off[1:0] = 2'b00;
				return {off, 5'd0, f3, 2'b00, r[8:6], rvIsaPkg::LOAD};
			end
			K_STORE:
			begin
				f3 = (r[13:12] == 2'b11) ? 3'b010 : {1'b0, r[13:12]};
				if (f3 == 3'b001)
					off[0] = 1'b0;
				if (f3 == 3'b010)
					off[1:0] = 2'b00;
				return {off[11:5], 2'b00, r[2:0], 5'd0, f3, off[4:0], rvIsaPkg::STORE};
			end
			K_BRANCH:
			begin
				immB = 13'((forwardTarget(s, r[25:24]) - s) * 4);
				return {immB[12], immB[10:5], 2'b00, r[2:0], 2'b00, r[5:3], r[13], 1'b0, r[12],
					immB[4:1], immB[11], rvIsaPkg::BRANCH};
			end
			K_JAL:
			begin
				immJ = 21'((forwardTarget(s, r[25:24]) - s) * 4);
				return {immJ[20], immJ[10:1], immJ[11], immJ[19:12], 2'b00, r[8:6], rvIsaPkg::JAL};
			end
			K_BASE: return {12'(forwardTarget(s + 1, r[25:24]) * 4), 5'd0, 3'b000, 5'd31,
				rvIsaPkg::OPIMM};
			K_JALR: return {11'b0, r[20], 5'd31, 3'b000, 2'b00, r[8:6], rvIsaPkg::JALR};
			default: return 32'h0;
		endcase
	endfunction

	task automatic buildProgram();
		logic [31:0] r;
		int s;
		for (int i = 0; i < `IMEM_WORDS; i++)
			progWords[i] = 32'h0;
		s = 0;
		while (s < PROG_LEN)
		begin
			r = nextRand();
			kinds[s] = (r[19:16] < 4'd4) ? K_OP : (r[19:16] < 4'd7) ? K_IMM :
				(r[19:16] < 4'd9) ? K_LOAD : (r[19:16] < 4'd11) ? K_STORE :
				(r[19:16] < 4'd13) ? K_BRANCH : (r[19:16] == 4'd13) ? K_JAL : K_BASE;
			if (kinds[s] == K_BASE && s < PROG_LEN - 1)
			begin
				kinds[s+1] = K_JALR;
				s = s + 2;
			end
			else
			begin
				if (kinds[s] == K_BASE)
					kinds[s] = K_IMM; // no room for the pair
				s++;
			end
		end
		kinds[PROG_LEN] = -1; // halt slot
		for (int i = 0; i < PROG_LEN; i++)
			progWords[i] = encodeSlot(i);
		progWords[PROG_LEN] = {20'h0, 5'd0, rvIsaPkg::JAL}; // jal x0, 0 as halt
	endtask

	initial
	begin
		@(negedge reset);
		#(TIMEOUT_NS);
		$display("Timeout: the core never reached the halt instruction");
		$display("SOME TESTS FAILED");
		$fatal(1);
	end

	initial
	begin
		coreCtrlPkg::retireT exp;
		int cycle;
		int lastRetire;
		logic done;
		imemLoad = 1'b0;
		imemLoadAddr = '0;
		imemLoadData = '0;
		lcgState = 32'h6081;
		modelPc = 32'h0;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = 32'h0;
		for (int i = 0; i < `DMEM_WORDS; i++)
			modelMem[i] = 32'h0;
		buildProgram();
		for (int i = 0; i <= PROG_LEN; i++)
		begin
			@(negedge clk);
			imemLoad = 1'b1;
			imemLoadAddr = i[`IMEM_AW-1:0];
			imemLoadData = progWords[i];
		end
		@(negedge clk);
		imemLoad = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		cycle = 0;
		lastRetire = -1; // first writeback lands three cycles after reset
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			cycle++;
			if (retireValid)
			begin
				checkValue("retire spacing", 32'(cycle - lastRetire), 32'd4);
				lastRetire = cycle;
				exp = modelStep();
				checkValue("pc", retire.pc, exp.pc);
				checkValue("regWriteEnable", 32'(retire.regWriteEnable), 32'(exp.regWriteEnable));
				checkValue("rd", 32'(retire.rd), 32'(exp.rd));
				checkValue("regWriteData", retire.regWriteData, exp.regWriteData);
				checkValue("memWriteEnable", 32'(retire.memWriteEnable), 32'(exp.memWriteEnable));
				checkValue("memAddr", retire.memAddr, exp.memAddr);
				checkValue("memByteEnable", 32'(retire.memByteEnable), 32'(exp.memByteEnable));
				checkValue("memWriteData", retire.memWriteData, exp.memWriteData);
				if (exp.pc == HALT_PC)
					done = 1'b1;
			end
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/rvCore_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCore_checker (
	input wire logic clk,
	input wire logic reset,
	input wire logic retireValid,
	input coreCtrlPkg::retireT retire
);

	assert property (@(posedge clk) disable iff (reset) retireValid |=> !retireValid)
		else $error("retireValid was high for more than one cycle");

	// one instruction every four cycles
	assert property (@(posedge clk) disable iff (reset)
		retireValid |=> !retireValid ##1 !retireValid ##1 !retireValid ##1 retireValid)
		else $error("retireValid pulses are not four cycles apart");

	assert property (@(posedge clk)
		reset |-> !retireValid && !retire.regWriteEnable && !retire.memWriteEnable)
		else $error("write enable active during reset");

	assert property (@(posedge clk) disable iff (reset)
		(retire.memByteEnable != 4'b0000) |-> retire.memWriteEnable)
		else $error("byte enables set without a memory write");

endmodule

bind rvCore rvCore_checker uChecker (
	.clk(clk),
	.reset(reset),
	.retireValid(retireValid),
	.retire(retire)
);

`default_nettype wire

/* design/rvCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module rvCore (
	input wire logic clk,
	input wire logic reset,
	input wire logic imemLoad,
	input wire logic [`IMEM_AW-1:0] imemLoadAddr,
	input wire logic [`DATA_WIDTH-1:0] imemLoadData,
	output logic retireValid,
	output coreCtrlPkg::retireT retire
);

	coreCtrlPkg::stateT state;
	coreCtrlPkg::execResultT result;
	rvIsaPkg::decodedT decoded;
	logic pcWriteEnable;
	logic [`DATA_WIDTH-1:0] pcWriteData;
	logic regWriteEnable;
	logic [`DATA_WIDTH-1:0] regWriteData;
	logic [`DATA_WIDTH-1:0] rs1Data;
	logic [`DATA_WIDTH-1:0] rs2Data;

	fetchDecode uFetchDecode (
		.clk(clk),
		.reset(reset),
		.imemLoad(imemLoad),
		.imemLoadAddr(imemLoadAddr),
		.imemLoadData(imemLoadData),
		.state(state),
		.pcWriteEnable(pcWriteEnable),
		.pcWriteData(pcWriteData),
		.decoded(decoded)
	);

	regFile uRegFile (
		.clk(clk),
		.reset(reset),
		.rs1(decoded.rs1),
		.rs2(decoded.rs2),
		.writeEnable(regWriteEnable),
		.rd(decoded.rd), // held stable through writeback
		.writeData(regWriteData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	execUnit uExecUnit (
		.clk(clk),
		.state(state),
		.decoded(decoded),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.result(result)
	);

	controller uController (
		.clk(clk),
		.reset(reset),
		.decoded(decoded),
		.result(result),
		.state(state),
		.regWriteEnable(regWriteEnable),
		.regWriteData(regWriteData),
		.pcWriteEnable(pcWriteEnable),
		.pcWriteData(pcWriteData),
		.retireValid(retireValid),
		.retire(retire)
	);

endmodule

`default_nettype wire

/* design/controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module controller (
	input wire logic clk,
	input wire logic reset,
	input rvIsaPkg::decodedT decoded,
	input coreCtrlPkg::execResultT result,
	output coreCtrlPkg::stateT state,
	output logic regWriteEnable,
	output logic [`DATA_WIDTH-1:0] regWriteData,
	output logic pcWriteEnable,
	output logic [`DATA_WIDTH-1:0] pcWriteData,
	output logic retireValid,
	output coreCtrlPkg::retireT retire
);

	coreCtrlPkg::stateT wbState;
	logic memWriteEnable;
	logic [3:0] memByteEnable;
	logic [`DATA_WIDTH-1:0] memWriteData;
	logic [`DATA_WIDTH-1:0] memReadData;
	logic [`DATA_WIDTH-1:0] readShifted;
	logic [`DATA_WIDTH-1:0] linkAddr;
	logic [4:0] laneShift;
	logic isMemOp;

	always_comb
	begin
		case (decoded.opcode)
			rvIsaPkg::LOAD: wbState = coreCtrlPkg::MEMREADREGWRITE;
			rvIsaPkg::STORE: wbState = coreCtrlPkg::MEMWRITE;
			rvIsaPkg::BRANCH: wbState = coreCtrlPkg::PCSELECTWRITE;
			rvIsaPkg::JAL, rvIsaPkg::JALR: wbState = coreCtrlPkg::PCWRITE;
			default: wbState = coreCtrlPkg::REGWRITE; // OP and OPIMM
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= coreCtrlPkg::FETCH;
		else
			case (state)
				coreCtrlPkg::FETCH: state <= coreCtrlPkg::DECODE;
				coreCtrlPkg::DECODE: state <= coreCtrlPkg::EXECUTE;
				coreCtrlPkg::EXECUTE: state <= wbState;
				default: state <= coreCtrlPkg::FETCH; // one writeback cycle
			endcase
	end

	// plain state driven enables
	assign retireValid = (state > coreCtrlPkg::EXECUTE);
	assign pcWriteEnable = retireValid;
	assign regWriteEnable = (state == coreCtrlPkg::REGWRITE) ||
		(state == coreCtrlPkg::MEMREADREGWRITE) || (state == coreCtrlPkg::PCWRITE);
	assign memWriteEnable = (state == coreCtrlPkg::MEMWRITE);
	assign isMemOp = memWriteEnable || (state == coreCtrlPkg::MEMREADREGWRITE);

	assign linkAddr = decoded.instrPc + 32'd4;
	assign laneShift = {result.aluOut[1:0], 3'b000}; // byte offset in bits
	assign readShifted = memReadData >> laneShift;

	always_comb
	begin
		memByteEnable = 4'b0000;
		memWriteData = '0;
		if (memWriteEnable)
		begin
			case (rvIsaPkg::memSizeT'(decoded.func3))
				rvIsaPkg::BYTE: memByteEnable = 4'b0001 << result.aluOut[1:0];
				rvIsaPkg::HALF: memByteEnable = 4'b0011 << result.aluOut[1:0];
				default: memByteEnable = 4'b1111; // sw
			endcase
			memWriteData = result.storeData << laneShift;
		end
	end

	always_comb
	begin
		case (state)
			coreCtrlPkg::REGWRITE: regWriteData = result.aluOut;
			coreCtrlPkg::MEMREADREGWRITE:
				case (rvIsaPkg::memSizeT'(decoded.func3))
					rvIsaPkg::BYTE: regWriteData = {{24{readShifted[7]}}, readShifted[7:0]};
					rvIsaPkg::HALF: regWriteData = {{16{readShifted[15]}}, readShifted[15:0]};
					rvIsaPkg::BYTEU: regWriteData = {24'b0, readShifted[7:0]};
					rvIsaPkg::HALFU: regWriteData = {16'b0, readShifted[15:0]};
					default: regWriteData = memReadData; // lw
				endcase
			coreCtrlPkg::PCWRITE: regWriteData = linkAddr; // jal, jalr link
			default: regWriteData = '0;
		endcase
	end

	always_comb
	begin
		pcWriteData = linkAddr;
		if (state == coreCtrlPkg::PCSELECTWRITE && result.branchTaken)
			pcWriteData = decoded.instrPc + decoded.imm;
		else if (state == coreCtrlPkg::PCWRITE)
			pcWriteData = (decoded.opcode == rvIsaPkg::JALR) ?
				{result.aluOut[`DATA_WIDTH-1:1], 1'b0} : decoded.instrPc + decoded.imm;
	end

	always_comb
	begin
		retire.pc = decoded.instrPc;
		retire.regWriteEnable = regWriteEnable;
		retire.rd = regWriteEnable ? decoded.rd : 5'd0;
		retire.regWriteData = regWriteData;
		retire.memWriteEnable = memWriteEnable;
		retire.memAddr = isMemOp ? result.aluOut : '0;
		retire.memByteEnable = memByteEnable;
		retire.memWriteData = memWriteData;
	end

	dataMem uDataMem (
		.clk(clk),
		.reset(reset),
		.addr(result.aluOut),
		.byteEnable(memByteEnable),
		.writeEnable(memWriteEnable),
		.writeData(memWriteData),
		.readData(memReadData)
	);

endmodule

`default_nettype wire

/* design/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module dataMem (
	input wire logic clk,
	input wire logic reset,
	input wire logic [`DATA_WIDTH-1:0] addr,
	input wire logic [3:0] byteEnable,
	input wire logic writeEnable,
	input wire logic [`DATA_WIDTH-1:0] writeData,
	output logic [`DATA_WIDTH-1:0] readData
);

	logic [`DATA_WIDTH-1:0] mem [`DMEM_WORDS];
	logic [`DMEM_AW-1:0] wordAddr;

	assign wordAddr = addr[`DMEM_AW+1:2]; // byte address to word index

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `DMEM_WORDS; i++)
				mem[i] <= '0;
		end
		else if (writeEnable)
		begin
			for (int b = 0; b < 4; b++)
				if (byteEnable[b])
					mem[wordAddr][8*b +: 8] <= writeData[8*b +: 8]; // lane already shifted
		end
	end

	assign readData = mem[wordAddr];

endmodule

`default_nettype wire

/* design/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module execUnit (
	input wire logic clk,
	input coreCtrlPkg::stateT state,
	input rvIsaPkg::decodedT decoded,
	input wire logic [`DATA_WIDTH-1:0] rs1Data,
	input wire logic [`DATA_WIDTH-1:0] rs2Data,
	output coreCtrlPkg::execResultT result
);

	logic [`DATA_WIDTH-1:0] operandB;
	logic [`DATA_WIDTH-1:0] aluOut;
	logic branchCond;

	assign operandB = decoded.useImm ? decoded.imm : rs2Data;

	// loads, stores and jalr decode to ADD, which gives rs1 + imm
	always_comb
	begin
		case (decoded.aluOp)
			rvIsaPkg::ADD: aluOut = rs1Data + operandB;
			rvIsaPkg::SUB: aluOut = rs1Data - operandB;
			rvIsaPkg::AND: aluOut = rs1Data & operandB;
			rvIsaPkg::OR: aluOut = rs1Data | operandB;
			rvIsaPkg::XOR: aluOut = rs1Data ^ operandB;
			rvIsaPkg::SLT: aluOut = {{(`DATA_WIDTH-1){1'b0}},
				$signed(rs1Data) < $signed(operandB)};
			default: aluOut = rs1Data + operandB;
		endcase
	end

	always_comb
	begin
		case (rvIsaPkg::branchT'(decoded.func3))
			rvIsaPkg::BEQ: branchCond = (rs1Data == rs2Data);
			rvIsaPkg::BNE: branchCond = (rs1Data != rs2Data);
			rvIsaPkg::BLT: branchCond = ($signed(rs1Data) < $signed(rs2Data));
			rvIsaPkg::BGE: branchCond = ($signed(rs1Data) >= $signed(rs2Data));
			default: branchCond = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (state == coreCtrlPkg::EXECUTE)
		begin
			result.aluOut <= aluOut;
			result.storeData <= rs2Data;
			result.branchTaken <= branchCond && (decoded.opcode == rvIsaPkg::BRANCH);
		end
	end

endmodule

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module regFile (
	input wire logic clk,
	input wire logic reset,
	input wire logic [4:0] rs1,
	input wire logic [4:0] rs2,
	input wire logic writeEnable,
	input wire logic [4:0] rd,
	input wire logic [`DATA_WIDTH-1:0] writeData,
	output logic [`DATA_WIDTH-1:0] rs1Data,
	output logic [`DATA_WIDTH-1:0] rs2Data
);

	logic [`DATA_WIDTH-1:0] regs [32];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && rd != 5'd0)
			regs[rd] <= writeData; // x0 never written
	end

	assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* design/fetchDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module fetchDecode (
	input wire logic clk,
	input wire logic reset,
	input wire logic imemLoad,
	input wire logic [`IMEM_AW-1:0] imemLoadAddr,
	input wire logic [`DATA_WIDTH-1:0] imemLoadData,
	input coreCtrlPkg::stateT state,
	input wire logic pcWriteEnable,
	input wire logic [`DATA_WIDTH-1:0] pcWriteData,
	output rvIsaPkg::decodedT decoded
);

	logic [`DATA_WIDTH-1:0] imem [`IMEM_WORDS];
	logic [`DATA_WIDTH-1:0] pc;
	logic [`DATA_WIDTH-1:0] instr;
	rvIsaPkg::decodedT nextDecoded;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;
		else if (pcWriteEnable)
			pc <= pcWriteData; // updated at the end of writeback
	end

	always_ff @(posedge clk)
	begin
		if (imemLoad)
			imem[imemLoadAddr] <= imemLoadData;
		if (state == coreCtrlPkg::FETCH)
			instr <= imem[pc[`IMEM_AW+1:2]];
		if (state == coreCtrlPkg::DECODE)
			decoded <= nextDecoded;
	end

	always_comb
	begin
		nextDecoded = '0;
		nextDecoded.opcode = rvIsaPkg::opcodeT'(instr[6:0]);
		nextDecoded.func3 = instr[14:12];
		nextDecoded.rd = instr[11:7];
		nextDecoded.rs1 = instr[19:15];
		nextDecoded.rs2 = instr[24:20];
		nextDecoded.instrPc = pc; // pc still points at this instruction
		nextDecoded.useImm = (nextDecoded.opcode != rvIsaPkg::OP);
		nextDecoded.aluOp = rvIsaPkg::ADD; // address sum by default
		case (nextDecoded.opcode)
			rvIsaPkg::OPIMM, rvIsaPkg::LOAD, rvIsaPkg::JALR:
				nextDecoded.imm = {{20{instr[31]}}, instr[31:20]};
			rvIsaPkg::STORE:
				nextDecoded.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			rvIsaPkg::BRANCH:
				nextDecoded.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			rvIsaPkg::JAL:
				nextDecoded.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			default:
				nextDecoded.imm = '0; // register ops
		endcase
		if (nextDecoded.opcode == rvIsaPkg::OP || nextDecoded.opcode == rvIsaPkg::OPIMM)
		begin
			case (rvIsaPkg::aluFunc3T'(instr[14:12]))
				rvIsaPkg::F3ADDSUB:
					nextDecoded.aluOp = (nextDecoded.opcode == rvIsaPkg::OP && instr[30]) ?
						rvIsaPkg::SUB : rvIsaPkg::ADD; // func7 bit 5 selects sub
				rvIsaPkg::F3SLT: nextDecoded.aluOp = rvIsaPkg::SLT;
				rvIsaPkg::F3XOR: nextDecoded.aluOp = rvIsaPkg::XOR;
				rvIsaPkg::F3OR: nextDecoded.aluOp = rvIsaPkg::OR;
				rvIsaPkg::F3AND: nextDecoded.aluOp = rvIsaPkg::AND;
				default: nextDecoded.aluOp = rvIsaPkg::ADD;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/coreCtrlPkg.sv */
`default_nettype none

`include "core_cfg.svh"

package coreCtrlPkg;

	typedef enum logic [3:0]
	{
		FETCH,
		DECODE,
		EXECUTE,
		REGWRITE, // alu result to rd
		MEMREADREGWRITE, // load
		MEMWRITE, // store
		PCSELECTWRITE, // branch
		PCWRITE // jal, jalr
	} stateT;

	typedef struct packed
	{
		logic [`DATA_WIDTH-1:0] aluOut;
		logic [`DATA_WIDTH-1:0] storeData; // rs2 value
		logic branchTaken;
	} execResultT;

	// one record per retired instruction
	typedef struct packed
	{
		logic [`DATA_WIDTH-1:0] pc;
		logic regWriteEnable;
		logic [4:0] rd;
		logic [`DATA_WIDTH-1:0] regWriteData;
		logic memWriteEnable;
		logic [`DATA_WIDTH-1:0] memAddr;
		logic [3:0] memByteEnable;
		logic [`DATA_WIDTH-1:0] memWriteData;
	} retireT;

endpackage

`default_nettype wire

/* design/rvIsaPkg.sv */
`default_nettype none

`include "core_cfg.svh"

package rvIsaPkg;

	typedef enum logic [6:0]
	{
		OP = 7'b0110011,
		OPIMM = 7'b0010011,
		LOAD = 7'b0000011,
		STORE = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL = 7'b1101111,
		JALR = 7'b1100111
	} opcodeT;

	// func3 of loads and stores
	typedef enum logic [2:0]
	{
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010,
		BYTEU = 3'b100,
		HALFU = 3'b101
	} memSizeT;

	// func3 of branches
	typedef enum logic [2:0]
	{
		BEQ = 3'b000,
		BNE = 3'b001,
		BLT = 3'b100,
		BGE = 3'b101
	} branchT;

	// func3 of register and immediate alu instructions
	typedef enum logic [2:0]
	{
		F3ADDSUB = 3'b000,
		F3SLT = 3'b010,
		F3XOR = 3'b100,
		F3OR = 3'b110,
		F3AND = 3'b111
	} aluFunc3T;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLT} aluOpT;

	typedef struct packed
	{
		opcodeT opcode;
		logic [2:0] func3;
		aluOpT aluOp;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [`DATA_WIDTH-1:0] imm; // sign extended per format
		logic useImm; // operand b is imm instead of rs2
		logic [`DATA_WIDTH-1:0] instrPc;
	} decodedT;

endpackage

`default_nettype wire

/* design/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define DATA_WIDTH 32 // data word and address width
`define IMEM_WORDS 64 // instruction memory depth
`define DMEM_WORDS 64 // data memory depth
`define IMEM_AW 6 // instruction memory word address bits
`define DMEM_AW 6 // data memory word address bits

`endif
